// ==== dv/program_input.txt ====
# P <word address> <instruction>: program word written through the load port.
# S <word address> <data>: expected store, in program order. All values hex.
P 00 ff900093  # addi x1, x0, -7
P 01 00300113  # addi x2, x0, 3
P 02 402081b3  # sub  x3, x1, x2
P 03 20302023  # sw   x3, 0x200(x0)
P 04 4010d213  # srai x4, x1, 1
P 05 20402223  # sw   x4, 0x204(x0)
P 06 0020a2b3  # slt  x5, x1, x2
P 07 20502423  # sw   x5, 0x208(x0)
P 08 0020b333  # sltu x6, x1, x2
P 09 20602623  # sw   x6, 0x20c(x0)
P 0a 0020c3b3  # xor  x7, x1, x2
P 0b 20702823  # sw   x7, 0x210(x0)
P 0c 12345437  # lui  x8, 0x12345
P 0d 20802a23  # sw   x8, 0x214(x0)
P 0e 00001497  # auipc x9, 0x1 at pc 0x38
P 0f 20902c23  # sw   x9, 0x218(x0)
P 10 0ff0000f  # fence
P 11 00208463  # beq  x1, x2, +8 not taken
P 12 20202e23  # sw   x2, 0x21c(x0)
P 13 00209463  # bne  x1, x2, +8 taken
P 14 22102023  # sw   x1, 0x220(x0) skipped
P 15 0020c463  # blt  x1, x2, +8 taken
P 16 22102023  # sw   x1, 0x220(x0) skipped
P 17 00117463  # bgeu x2, x1, +8 not taken
P 18 22502023  # sw   x5, 0x220(x0)
P 19 0080056f  # jal  x10, +8
P 1a 22102223  # sw   x1, 0x224(x0) skipped
P 1b 22a02223  # sw   x10, 0x224(x0)
P 1c 07f00593  # addi x11, x0, 0x7f
P 1d 00258667  # jalr x12, 2(x11) lands on 0x80
P 1e 22102423  # sw   x1, 0x228(x0) skipped
P 1f 22102423  # sw   x1, 0x228(x0) skipped
P 20 22c02423  # sw   x12, 0x228(x0)
P 21 22702623  # sw   x7, 0x22c(x0)
P 22 22c02683  # lw   x13, 0x22c(x0)
P 23 00168013  # addi x0, x13, 1
P 24 00168693  # addi x13, x13, 1
P 25 22d02823  # sw   x13, 0x230(x0)
P 26 22002a23  # sw   x0, 0x234(x0)
P 27 0000006f  # jal  x0, 0
S 80 fffffff6  # -7 - 3
S 81 fffffffc  # -7 >>> 1
S 82 00000001  # -7 < 3 signed
S 83 00000000  # -7 < 3 unsigned
S 84 fffffffa  # xor
S 85 12345000  # lui
S 86 00001038  # auipc
S 87 00000003  # beq fall-through marker
S 88 00000001  # bgeu fall-through marker
S 89 00000068  # jal link
S 8a 00000078  # jalr link
S 8b fffffffa  # word for the load
S 8c fffffffb  # loaded word plus one
S 8d 00000000  # x0 after a write

// ==== project.f ====
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/core_ctrl_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/unified_memory.sv
verilog/multicycle_control.sv
verilog/core_datapath.sv
verilog/multicycle_core.sv
dv/clock_gen.sv
dv/tb_multicycle_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_multicycle_core
BUILD_DIR ?= build
FILELIST  ?= project.f
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The pass line in the output decides the result.
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/tb_multicycle_core.sv ====
/*
 * Testbench for the multicycle core.
 * Loads the program from the input data file, runs it and checks every store in order.
 */
module tb_multicycle_core;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;

    localparam string INPUT_FILE      = "dv/program_input.txt";
    localparam int    RESET_CYCLES    = 5;
    localparam int    DRIVE_DELAY     = 1;
    localparam int    CYCLES_PER_WORD = 8;
    localparam int    TIMEOUT_MARGIN  = 100;
    localparam int    NEWLINE         = 10;

    logic       clock;
    logic       reset;
    logic       run;
    logic       load_write;
    word_addr_t load_address;
    xlen_t      load_data;
    logic       store_valid;
    word_addr_t store_address;
    xlen_t      store_data;

    word_addr_t program_address [$];
    xlen_t      program_word [$];
    word_addr_t expected_address [$];
    xlen_t      expected_data [$];

    int store_index;
    int cycle_count;
    int cycle_limit;

    clock_gen u_clock_gen (
        .clock (clock)
    );

    multicycle_core dut (
        .clock         (clock),
        .reset         (reset),
        .run           (run),
        .load_write    (load_write),
        .load_address  (load_address),
        .load_data     (load_data),
        .store_valid   (store_valid),
        .store_address (store_address),
        .store_data    (store_data)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_address(input int index, input word_addr_t actual,
                                   input word_addr_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: store %0d address %h, expected %h",
                                $time, index, actual, expected));
        end
    endtask

    task automatic compare_data(input int index, input xlen_t actual, input xlen_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: store %0d data %h, expected %h",
                                $time, index, actual, expected));
        end
    endtask

    // P lines hold program words, S lines the expected stores.
    task automatic read_input();
        int          fd;
        int          code;
        int          ch;
        logic [7:0]  tag;
        logic [31:0] field_a;
        logic [31:0] field_b;

        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            abort_run($sformatf("cannot open the input data file %s", INPUT_FILE));
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                ch = 0;
                while (ch != NEWLINE && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else begin
                code = $fscanf(fd, "%h %h", field_a, field_b);
                if (code != 2) begin
                    abort_run("the input data file has a line without two hex fields");
                end
                if (tag == "P") begin
                    program_address.push_back(word_addr_t'(field_a));
                    program_word.push_back(field_b);
                end else if (tag == "S") begin
                    expected_address.push_back(word_addr_t'(field_a));
                    expected_data.push_back(field_b);
                end else begin
                    abort_run("the input data file has a line with an unknown tag");
                end
            end
        end
        $fclose(fd);
        if (program_word.size() == 0 || expected_data.size() == 0) begin
            abort_run("the input data file holds no program or no expected stores");
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < program_word.size(); i++) begin
            @(posedge clock);
            #(DRIVE_DELAY);
            load_write   = 1'b1;
            load_address = program_address[i];
            load_data    = program_word[i];
        end
        @(posedge clock);
        #(DRIVE_DELAY);
        load_write = 1'b0;
    endtask

    // The core is held while run is low.
    always @(negedge clock) begin
        if (!run && store_valid === 1'b1) begin
            abort_run("a store appeared while run was low");
        end
    end

    initial begin
        reset        = 1'b1;
        run          = 1'b0;
        load_write   = 1'b0;
        load_address = '0;
        load_data    = '0;
        store_index  = 0;
        cycle_count  = 0;

        read_input();
        cycle_limit = CYCLES_PER_WORD * program_word.size() + TIMEOUT_MARGIN;

        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        reset = 1'b0;

        load_program();
        run = 1'b1;

        // Stores sampled mid-cycle.
        while (store_index < expected_data.size() && cycle_count < cycle_limit) begin
            @(negedge clock);
            cycle_count++;
            if (store_valid === 1'b1) begin
                compare_address(store_index, store_address, expected_address[store_index]);
                compare_data(store_index, store_data, expected_data[store_index]);
                store_index++;
            end
        end

        if (store_index == expected_data.size()) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
                                cycle_count, store_index, expected_data.size()));
        end
    end

endmodule

// ==== dv/clock_gen.sv ====
/*
 * Free-running testbench clock with a 100 ns period.
 */
module clock_gen (
    output logic clock
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 50;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

endmodule

// ==== verilog/multicycle_core.sv ====
/*
 * Top of the multicycle RV32I core with program load and store observation ports.
 */
module multicycle_core (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   run,
    input  logic                   load_write,
    input  rv_isa_pkg::word_addr_t load_address,
    input  rv_isa_pkg::xlen_t      load_data,
    output logic                   store_valid,
    output rv_isa_pkg::word_addr_t store_address,
    output rv_isa_pkg::xlen_t      store_data
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    ctrl_t      ctrl;
    opcode_t    inst_opcode;
    logic       take_branch;
    word_addr_t mem_address;
    xlen_t      mem_write_data;
    xlen_t      mem_read_data;
    logic       mem_write;

    assign store_valid   = mem_write;
    assign store_address = mem_address;
    assign store_data    = mem_write_data;

    multicycle_control u_control (
        .clock       (clock),
        .reset       (reset),
        .run         (run),
        .inst_opcode (inst_opcode),
        .take_branch (take_branch),
        .ctrl        (ctrl)
    );

    // The memory reads every cycle and needs no read strobe.
    core_datapath u_datapath (
        .clock          (clock),
        .reset          (reset),
        .ctrl           (ctrl),
        .inst_opcode    (inst_opcode),
        .take_branch    (take_branch),
        .mem_address    (mem_address),
        .mem_write_data (mem_write_data),
        .mem_read       (),
        .mem_write      (mem_write),
        .mem_read_data  (mem_read_data)
    );

    unified_memory u_memory (
        .clock        (clock),
        .address      (mem_address),
        .read_data    (mem_read_data),
        .write_enable (mem_write),
        .write_data   (mem_write_data),
        .load_write   (load_write),
        .load_address (load_address),
        .load_data    (load_data)
    );

endmodule

// ==== verilog/core_datapath.sv ====
/*
 * Datapath of the multicycle core.
 * Registers, immediate decode and operand muxes, steered by the control bundle.
 */
`include "core_config.svh"

module core_datapath (
    input  logic                   clock,
    input  logic                   reset,
    input  core_ctrl_pkg::ctrl_t   ctrl,
    output rv_isa_pkg::opcode_t    inst_opcode,
    output logic                   take_branch,
    output rv_isa_pkg::word_addr_t mem_address,
    output rv_isa_pkg::xlen_t      mem_write_data,
    output logic                   mem_read,
    output logic                   mem_write,
    input  rv_isa_pkg::xlen_t      mem_read_data
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int ADDR_BITS = $bits(word_addr_t);

    xlen_t pc;
    xlen_t last_pc;
    xlen_t inst;
    xlen_t data;
    xlen_t alu_out;
    xlen_t imm;
    xlen_t rs1;
    xlen_t rs2;
    xlen_t alu_a;
    xlen_t alu_b;
    xlen_t alu_result;
    xlen_t pc_next;
    xlen_t wb_data;
    xlen_t byte_address;

    assign inst_opcode = opcode_t'(inst[6:0]);

    always_comb begin
        case (inst_opcode)
            OPCODE_STORE:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OPCODE_BRANCH: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                  inst[11:8], 1'b0};
            OPCODE_LUI, OPCODE_AUIPC: imm = {inst[31:12], 12'b0};
            OPCODE_JAL:    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                  inst[30:21], 1'b0};
            default:       imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

    always_comb begin
        case (ctrl.alu_a_sel)
            A_PC:      alu_a = pc;
            A_LAST_PC: alu_a = last_pc;
            default:   alu_a = rs1;
        endcase
        case (ctrl.alu_b_sel)
            B_FOUR:  alu_b = 32'd4;
            B_IMM:   alu_b = imm;
            default: alu_b = rs2;
        endcase
        case (ctrl.wb_sel)
            WB_ALU:  wb_data = alu_out;
            WB_DATA: wb_data = data;
            WB_IMM:  wb_data = imm;
            default: wb_data = pc;
        endcase
    end

    // JALR clears bit 0 of its target.
    assign pc_next = (ctrl.pc_sel == PC_ALU_OUT) ? alu_out : {alu_result[31:1], 1'b0};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (ctrl.pc_write) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.last_pc_write) begin
            last_pc <= pc;
        end
        if (ctrl.inst_write) begin
            inst <= mem_read_data;
        end
        if (ctrl.data_write) begin
            data <= mem_read_data;
        end
        if (ctrl.alu_out_write) begin
            alu_out <= alu_result;
        end
    end

    assign byte_address   = ctrl.inst_or_data ? alu_out : pc;
    assign mem_address    = byte_address[ADDR_BITS+1:2];
    assign mem_write_data = rs2;
    assign mem_read       = ctrl.mem_read;
    assign mem_write      = ctrl.mem_write;

    alu u_alu (
        .op          (ctrl.alu_op),
        .funct3      (inst[14:12]),
        .funct7      (inst[31:25]),
        .a           (alu_a),
        .b           (alu_b),
        .result      (alu_result),
        .take_branch (take_branch)
    );

    register_file u_register_file (
        .clock          (clock),
        .reset          (reset),
        .read_address_a (inst[19:15]),
        .read_address_b (inst[24:20]),
        .read_data_a    (rs1),
        .read_data_b    (rs2),
        .write_enable   (ctrl.regfile_write),
        .write_address  (inst[11:7]),
        .write_data     (wb_data)
    );

endmodule

// ==== verilog/multicycle_control.sv ====
/*
 * Multicycle FSM that sequences fetch, decode, execute, memory and writeback.
 * Holds in fetch with all enables low while run is low.
 */
module multicycle_control (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 run,
    input  rv_isa_pkg::opcode_t  inst_opcode,
    input  logic                 take_branch,
    output core_ctrl_pkg::ctrl_t ctrl
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        EXECUTE,
        EXECUTE_IMM,
        ALU_WRITEBACK,
        MEM_ADDR,
        MEM_READ,
        MEM_WRITE,
        MEM_WRITEBACK,
        BRANCH,
        LUI,
        JAL,
        JALR
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = FETCH;
        case (state)
            FETCH: state_next = run ? DECODE : FETCH;
            DECODE: begin
                case (inst_opcode)
                    OPCODE_LOAD, OPCODE_STORE: state_next = MEM_ADDR;
                    OPCODE_BRANCH: state_next = BRANCH;
                    OPCODE_JAL:    state_next = JAL;
                    OPCODE_JALR:   state_next = JALR;
                    OPCODE_OP:     state_next = EXECUTE;
                    OPCODE_OP_IMM: state_next = EXECUTE_IMM;
                    OPCODE_LUI:    state_next = LUI;
                    // AUIPC sum is already in the ALU-output register.
                    OPCODE_AUIPC:  state_next = ALU_WRITEBACK;
                    default:       state_next = FETCH;
                endcase
            end
            EXECUTE, EXECUTE_IMM: state_next = ALU_WRITEBACK;
            MEM_ADDR: state_next = (inst_opcode == OPCODE_LOAD) ? MEM_READ : MEM_WRITE;
            MEM_READ: state_next = MEM_WRITEBACK;
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        ctrl = '0;
        case (state)
            FETCH: begin
                if (run) begin
                    ctrl.mem_read      = 1'b1;
                    ctrl.inst_write    = 1'b1;
                    ctrl.last_pc_write = 1'b1;
                    ctrl.pc_write      = 1'b1;
                    ctrl.alu_op        = ALU_ADD;
                    ctrl.alu_a_sel     = A_PC;
                    ctrl.alu_b_sel     = B_FOUR;
                    ctrl.pc_sel        = PC_ALU_RES;
                end
            end
            DECODE: begin
                // Branch, jump and AUIPC target from the fetched PC.
                ctrl.alu_op        = ALU_ADD;
                ctrl.alu_a_sel     = A_LAST_PC;
                ctrl.alu_b_sel     = B_IMM;
                ctrl.alu_out_write = 1'b1;
            end
            EXECUTE: begin
                ctrl.alu_op        = ALU_OP;
                ctrl.alu_a_sel     = A_RS1;
                ctrl.alu_b_sel     = B_RS2;
                ctrl.alu_out_write = 1'b1;
            end
            EXECUTE_IMM: begin
                ctrl.alu_op        = ALU_OP_IMM;
                ctrl.alu_a_sel     = A_RS1;
                ctrl.alu_b_sel     = B_IMM;
                ctrl.alu_out_write = 1'b1;
            end
            ALU_WRITEBACK: begin
                ctrl.regfile_write = 1'b1;
                ctrl.wb_sel        = WB_ALU;
            end
            MEM_ADDR: begin
                ctrl.alu_op        = ALU_ADD;
                ctrl.alu_a_sel     = A_RS1;
                ctrl.alu_b_sel     = B_IMM;
                ctrl.alu_out_write = 1'b1;
            end
            MEM_READ: begin
                ctrl.inst_or_data = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.data_write   = 1'b1;
            end
            MEM_WRITE: begin
                ctrl.inst_or_data = 1'b1;
                ctrl.mem_write    = 1'b1;
            end
            MEM_WRITEBACK: begin
                ctrl.regfile_write = 1'b1;
                ctrl.wb_sel        = WB_DATA;
            end
            BRANCH: begin
                ctrl.alu_op    = ALU_BRANCH;
                ctrl.alu_a_sel = A_RS1;
                ctrl.alu_b_sel = B_RS2;
                ctrl.pc_write  = take_branch;
                ctrl.pc_sel    = PC_ALU_OUT;
            end
            LUI: begin
                ctrl.regfile_write = 1'b1;
                ctrl.wb_sel        = WB_IMM;
            end
            JAL: begin
                ctrl.regfile_write = 1'b1;
                ctrl.wb_sel        = WB_PC4;
                ctrl.pc_write      = 1'b1;
                ctrl.pc_sel        = PC_ALU_OUT;
            end
            JALR: begin
                ctrl.regfile_write = 1'b1;
                ctrl.wb_sel        = WB_PC4;
                ctrl.alu_op        = ALU_ADD;
                ctrl.alu_a_sel     = A_RS1;
                ctrl.alu_b_sel     = B_IMM;
                ctrl.pc_write      = 1'b1;
                ctrl.pc_sel        = PC_ALU_RES;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    a_supported_opcode: assert property (
        @(posedge clock) disable iff (reset)
        state == DECODE |-> inst_opcode inside {
            OPCODE_LOAD, OPCODE_STORE, OPCODE_BRANCH, OPCODE_JAL, OPCODE_JALR,
            OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC, OPCODE_MISC_MEM}
    ) else $error("unsupported opcode %b", inst_opcode);

endmodule

// ==== verilog/unified_memory.sv ====
/*
 * Word memory shared by instruction fetch and data access.
 * A second write port loads the program while the core is idle.
 */
`include "core_config.svh"

module unified_memory (
    input  logic                   clock,
    input  rv_isa_pkg::word_addr_t address,
    output rv_isa_pkg::xlen_t      read_data,
    input  logic                   write_enable,
    input  rv_isa_pkg::xlen_t      write_data,
    input  logic                   load_write,
    input  rv_isa_pkg::word_addr_t load_address,
    input  rv_isa_pkg::xlen_t      load_data
);
    import rv_isa_pkg::*;

    xlen_t mem [`MEM_WORDS];

    // Load port wins.
    always_ff @(posedge clock) begin
        if (load_write) begin
            mem[load_address] <= load_data;
        end else if (write_enable) begin
            mem[address] <= write_data;
        end
    end

    assign read_data = mem[address];

    a_no_write_during_load: assert property (
        @(posedge clock) !(write_enable && load_write)
    ) else $error("core store while program load is active");

endmodule

// ==== verilog/register_file.sv ====
/*
 * Integer register file, two combinational reads and one clocked write.
 */
module register_file (
    input  logic                  clock,
    input  logic                  reset,
    input  rv_isa_pkg::reg_addr_t read_address_a,
    input  rv_isa_pkg::reg_addr_t read_address_b,
    output rv_isa_pkg::xlen_t     read_data_a,
    output rv_isa_pkg::xlen_t     read_data_b,
    input  logic                  write_enable,
    input  rv_isa_pkg::reg_addr_t write_address,
    input  rv_isa_pkg::xlen_t     write_data
);
    import rv_isa_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_address != '0) begin
            regs[write_address] <= write_data;
        end
    end

    assign read_data_a = regs[read_address_a];
    assign read_data_b = regs[read_address_b];

endmodule

// ==== verilog/alu.sv ====
/*
 * Combinational RV32I ALU with branch comparison.
 */
module alu (
    input  core_ctrl_pkg::alu_op_t op,
    input  rv_isa_pkg::funct3_t    funct3,
    input  rv_isa_pkg::funct7_t    funct7,
    input  rv_isa_pkg::xlen_t      a,
    input  rv_isa_pkg::xlen_t      b,
    output rv_isa_pkg::xlen_t      result,
    output logic                   take_branch
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        result      = a + b;
        take_branch = 1'b0;
        case (op)
            ALU_OP, ALU_OP_IMM: begin
                case (funct3)
                    // Immediate form has no SUB.
                    3'b000: result = (op == ALU_OP && funct7[5]) ? a - b : a + b;
                    3'b001: result = a << shamt;
                    3'b010: result = {31'b0, $signed(a) < $signed(b)};
                    3'b011: result = {31'b0, a < b};
                    3'b100: result = a ^ b;
                    3'b101: result = funct7[5] ? xlen_t'($signed(a) >>> shamt) : a >> shamt;
                    3'b110: result = a | b;
                    default: result = a & b;
                endcase
            end
            ALU_BRANCH: begin
                case (funct3)
                    3'b000: take_branch = (a == b);
                    3'b001: take_branch = (a != b);
                    3'b100: take_branch = $signed(a) < $signed(b);
                    3'b101: take_branch = $signed(a) >= $signed(b);
                    3'b110: take_branch = a < b;
                    3'b111: take_branch = a >= b;
                    default: take_branch = 1'b0;
                endcase
            end
            default: result = a + b;
        endcase
    end

endmodule

// ==== verilog/core_ctrl_pkg.sv ====
/*
 * Control-side types of the multicycle core.
 * The controller drives one ctrl_t bundle that the datapath decodes.
 */
package core_ctrl_pkg;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_OP,
        ALU_OP_IMM,
        ALU_BRANCH
    } alu_op_t;

    typedef enum logic [1:0] {
        A_PC,
        A_LAST_PC,
        A_RS1
    } alu_a_sel_t;

    typedef enum logic [1:0] {
        B_FOUR,
        B_IMM,
        B_RS2
    } alu_b_sel_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_DATA,
        WB_IMM,
        WB_PC4
    } wb_sel_t;

    // ALU_RES takes the live ALU result, ALU_OUT the registered one.
    typedef enum logic {
        PC_ALU_RES,
        PC_ALU_OUT
    } pc_sel_t;

    typedef struct packed {
        alu_op_t    alu_op;
        alu_a_sel_t alu_a_sel;
        alu_b_sel_t alu_b_sel;
        logic       pc_write;
        logic       last_pc_write;
        logic       alu_out_write;
        logic       inst_write;
        logic       data_write;
        logic       regfile_write;
        logic       mem_read;
        logic       mem_write;
        wb_sel_t    wb_sel;
        logic       inst_or_data;
        pc_sel_t    pc_sel;
    } ctrl_t;

endpackage

// ==== verilog/rv_isa_pkg.sv ====
/*
 * RV32I instruction-set types shared by the core.
 * Covers data words, register and memory indexes and instruction fields.
 */
`include "core_config.svh"

package rv_isa_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    // Word index into the unified memory.
    typedef logic [$clog2(`MEM_WORDS)-1:0] word_addr_t;

    // Major opcodes of the supported subset.
    typedef enum logic [6:0] {
        OPCODE_LOAD     = 7'b0000011,
        OPCODE_MISC_MEM = 7'b0001111,
        OPCODE_OP_IMM   = 7'b0010011,
        OPCODE_AUIPC    = 7'b0010111,
        OPCODE_STORE    = 7'b0100011,
        OPCODE_OP       = 7'b0110011,
        OPCODE_LUI      = 7'b0110111,
        OPCODE_BRANCH   = 7'b1100011,
        OPCODE_JALR     = 7'b1100111,
        OPCODE_JAL      = 7'b1101111
    } opcode_t;

    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

endpackage

// ==== verilog/core_config.svh ====
/*
 * Build-time sizes for the multicycle core.
 * Included by the ISA package, the datapath and the memory.
 */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Depth of the unified instruction and data memory, in 32-bit words.
`define MEM_WORDS 256

// Byte address of the first fetch after reset.
`define RESET_PC 32'h0000_0000

`endif
